//--- Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       ?= rv32_mini_tb
FILELIST  ?= rv32_mini.f
BUILD_DIR ?= obj_dir

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP)

clean:
	rm -rf $(BUILD_DIR)

//--- rtl/decode.sv
`timescale 1ns/100ps

module decode import rv32_pkg::*; (
  input  inst_t inst,
  output dec_t  dec
);

  // funct3 to ALU op, alt picks SUB or SRA
  function automatic alu_func_e alu_map(input logic [2:0] funct3, input logic alt);
    case (funct3)
      3'b000:  alu_map = alt ? SUB : ADD;
      3'b001:  alu_map = SLL;
      3'b010:  alu_map = SLT;
      3'b011:  alu_map = SLTU;
      3'b100:  alu_map = XOR;
      3'b101:  alu_map = alt ? SRA : SRL;
      3'b110:  alu_map = OR;
      default: alu_map = AND;
    endcase
  endfunction

  logic [2:0] funct3;
  logic [6:0] funct7;

  assign funct3 = inst.r_fmt.funct3;
  assign funct7 = inst.r_fmt.funct7;

  always_comb begin
    dec          = '0;
    dec.itype    = NOP;
    dec.alu_func = ADD;
    dec.br_func  = EQ;
    dec.rs1      = inst.r_fmt.rs1; // same bit position in every format
    dec.rs2      = inst.r_fmt.rs2;
    case (inst.r_fmt.opcode)
      OPC_OP: begin
        if (funct7 == 7'h00 || (funct7 == 7'h20 && (funct3 == 3'b000 || funct3 == 3'b101))) begin
          dec.itype    = OP;
          dec.alu_func = alu_map(funct3, funct7[5]);
          dec.rd       = inst.r_fmt.rd;
        end
      end
      OPC_OPIMM: begin
        dec.itype    = OPIMM;
        dec.alu_func = alu_map(funct3, funct3 == 3'b101 && funct7[5]);
        dec.rd       = inst.i_fmt.rd;
        dec.imm      = {{20{inst.i_fmt.imm_11_0[11]}}, inst.i_fmt.imm_11_0};
      end
      OPC_LUI, OPC_AUIPC: begin
        dec.itype = (inst.u_fmt.opcode == OPC_LUI) ? LUI : AUIPC;
        dec.rd    = inst.u_fmt.rd;
        dec.imm   = {inst.u_fmt.imm_31_12, 12'b0};
      end
      OPC_JAL: begin
        dec.itype = JAL;
        dec.rd    = inst.j_fmt.rd;
        dec.imm   = {{11{inst.j_fmt.imm_20}}, inst.j_fmt.imm_20, inst.j_fmt.imm_19_12,
                     inst.j_fmt.imm_11, inst.j_fmt.imm_10_1, 1'b0};
      end
      OPC_JALR: begin
        dec.itype = JALR;
        dec.rd    = inst.i_fmt.rd;
        dec.imm   = {{20{inst.i_fmt.imm_11_0[11]}}, inst.i_fmt.imm_11_0};
      end
      OPC_BRANCH: begin
        dec.imm = {{19{inst.b_fmt.imm_12}}, inst.b_fmt.imm_12, inst.b_fmt.imm_11,
                   inst.b_fmt.imm_10_5, inst.b_fmt.imm_4_1, 1'b0};
        dec.itype = BRANCH;
        case (funct3)
          3'b000:  dec.br_func = EQ;
          3'b001:  dec.br_func = NE;
          3'b100:  dec.br_func = LT;
          3'b101:  dec.br_func = GE;
          3'b110:  dec.br_func = LTU;
          3'b111:  dec.br_func = GEU;
          default: dec.itype   = NOP;
        endcase
      end
      OPC_LOAD: begin
        if (funct3 == 3'b010) begin // LW only
          dec.itype = LOAD;
          dec.rd    = inst.i_fmt.rd;
          dec.imm   = {{20{inst.i_fmt.imm_11_0[11]}}, inst.i_fmt.imm_11_0};
        end
      end
      OPC_STORE: begin
        if (funct3 == 3'b010) begin
          dec.itype = STORE;
          dec.imm   = {{20{inst.s_fmt.imm_11_5[6]}}, inst.s_fmt.imm_11_5, inst.s_fmt.imm_4_0};
        end
      end
      default: dec.itype = NOP; // unknown opcode retires as no-op
    endcase
  end

endmodule

//--- rtl/execute.sv
`timescale 1ns/100ps

module execute import rv32_pkg::*; (
  input  dec_t        dec,
  input  logic [31:0] pc,
  input  logic [31:0] rval1,
  input  logic [31:0] rval2,
  output exe_t        exe
);

  logic [31:0] op_b;
  logic [31:0] alu_out;
  logic [31:0] target;
  logic        taken;

  assign op_b = (dec.itype == OP) ? rval2 : dec.imm;

  always_comb begin
    case (dec.alu_func)
      ADD:     alu_out = rval1 + op_b;
      SUB:     alu_out = rval1 - op_b;
      SLL:     alu_out = rval1 << op_b[4:0];
      SLT:     alu_out = {31'b0, $signed(rval1) < $signed(op_b)};
      SLTU:    alu_out = {31'b0, rval1 < op_b};
      XOR:     alu_out = rval1 ^ op_b;
      SRL:     alu_out = rval1 >> op_b[4:0];
      SRA:     alu_out = $signed(rval1) >>> op_b[4:0];
      OR:      alu_out = rval1 | op_b;
      default: alu_out = rval1 & op_b;
    endcase
  end

  always_comb begin
    case (dec.br_func)
      EQ:      taken = (rval1 == rval2);
      NE:      taken = (rval1 != rval2);
      LT:      taken = ($signed(rval1) < $signed(rval2));
      GE:      taken = ($signed(rval1) >= $signed(rval2));
      LTU:     taken = (rval1 < rval2);
      default: taken = (rval1 >= rval2);
    endcase
  end

  assign target = pc + dec.imm; // branch and JAL target

  always_comb begin
    case (dec.itype)
      LUI:       exe.result = dec.imm;
      AUIPC:     exe.result = target;
      JAL, JALR: exe.result = pc + 32'd4; // link address
      default:   exe.result = alu_out;
    endcase

    case (dec.itype)
      JAL:     exe.next_pc = target;
      JALR:    exe.next_pc = (rval1 + dec.imm) & ~32'd1;
      BRANCH:  exe.next_pc = taken ? target : pc + 32'd4;
      default: exe.next_pc = pc + 32'd4;
    endcase
  end

  assign exe.addr       = rval1 + dec.imm;
  assign exe.store_data = rval2;

endmodule

//--- rtl/fetch_unit.sv
`timescale 1ns/100ps

module fetch_unit import rv32_pkg::*; #(
  parameter logic [31:0] reset_pc = 32'h0
) (
  input  logic        clk_100mhz,
  input  logic        sys_rst,
  output wb_m2s_t     ibus_m2s,
  input  wb_s2m_t     ibus_s2m,
  input  logic [31:0] next_pc,
  input  logic        done,
  output logic [31:0] pc,
  output inst_t       inst,
  output logic        inst_ready
);

  typedef enum logic {FETCHING, EXECUTING} state_e;

  state_e state;
  logic   req; // cyc and stb of the instruction bus

  always_ff @(posedge clk_100mhz) begin
    if (sys_rst) begin
      state <= FETCHING;
      req   <= 1'b0;
      pc    <= reset_pc;
    end else begin
      case (state)
        FETCHING: begin
          if (req && ibus_s2m.ack) begin
            req   <= 1'b0; // drop in the cycle after ack
            state <= EXECUTING;
          end else begin
            req <= 1'b1;
          end
        end
        EXECUTING: begin
          if (done) begin
            pc    <= next_pc;
            req   <= 1'b1; // next fetch right away
            state <= FETCHING;
          end
        end
        default: state <= FETCHING;
      endcase
    end
  end

  // latch the fetched word
  always_ff @(posedge clk_100mhz) begin
    if (state == FETCHING && req && ibus_s2m.ack) inst <= ibus_s2m.dat;
  end

  assign inst_ready = (state == EXECUTING);

  assign ibus_m2s.cyc = req;
  assign ibus_m2s.stb = req;
  assign ibus_m2s.we  = 1'b0;
  assign ibus_m2s.adr = pc;
  assign ibus_m2s.dat = '0;
  assign ibus_m2s.sel = 4'hf; // word reads only

endmodule

//--- rtl/mem_writeback.sv
`timescale 1ns/100ps

module mem_writeback import rv32_pkg::*; (
  input  logic        clk_100mhz,
  input  logic        sys_rst,
  input  logic        inst_ready,
  input  dec_t        dec,
  input  exe_t        exe,
  input  logic [31:0] pc,
  output wb_m2s_t     dbus_m2s,
  input  wb_s2m_t     dbus_s2m,
  output logic        we,
  output logic [4:0]  wa,
  output logic [31:0] wd,
  output logic        done,
  output logic        retire_valid,
  output retire_t     retire
);

  logic is_mem;
  logic writes_rd;
  logic req;

  assign is_mem = (dec.itype == LOAD) || (dec.itype == STORE);

  // branch, store and no-op never write
  assign writes_rd = (dec.itype != BRANCH) && (dec.itype != STORE) && (dec.itype != NOP)
                     && (dec.rd != 5'd0);

  // held from the first execute cycle until ack, drops once fetch resumes
  assign req = inst_ready && is_mem;

  assign dbus_m2s.cyc = req;
  assign dbus_m2s.stb = req;
  assign dbus_m2s.we  = (dec.itype == STORE);
  assign dbus_m2s.adr = exe.addr;
  assign dbus_m2s.dat = exe.store_data;
  assign dbus_m2s.sel = 4'hf;

  assign done = inst_ready && (!is_mem || dbus_s2m.ack);

  assign we = done && writes_rd;
  assign wa = dec.rd;
  assign wd = (dec.itype == LOAD) ? dbus_s2m.dat : exe.result; // load data valid with ack

  always_ff @(posedge clk_100mhz) begin
    if (sys_rst) begin
      retire_valid <= 1'b0;
    end else begin
      retire_valid <= done;
    end
  end

  // record of the instruction just completed
  always_ff @(posedge clk_100mhz) begin
    if (done) begin
      retire.pc      <= pc;
      retire.rd      <= dec.rd;
      retire.we      <= writes_rd;
      retire.wd      <= wd;
      retire.next_pc <= exe.next_pc;
    end
  end

endmodule

//--- rtl/register_file.sv
`timescale 1ns/100ps

module register_file (
  input  logic        clk_100mhz,
  input  logic        sys_rst,
  input  logic [4:0]  rs1,
  input  logic [4:0]  rs2,
  input  logic        we,
  input  logic [4:0]  wa,
  input  logic [31:0] wd,
  output logic [31:0] rval1,
  output logic [31:0] rval2
);

  logic [31:0] regs [1:31]; // x0 has no storage

  always_ff @(posedge clk_100mhz) begin
    if (sys_rst) begin
      for (int i = 1; i < 32; i++) regs[i] <= '0;
    end else if (we && wa != 5'd0) begin
      regs[wa] <= wd;
    end
  end

  // x0 reads zero
  assign rval1 = (rs1 == 5'd0) ? '0 : regs[rs1];
  assign rval2 = (rs2 == 5'd0) ? '0 : regs[rs2];

endmodule

//--- rtl/rv32_mini_top.sv
`timescale 1ns/100ps

module rv32_mini_top import rv32_pkg::*; #(
  parameter logic [31:0] reset_pc = 32'h0
) (
  input  logic    clk_100mhz,
  input  logic    sys_rst,
  output wb_m2s_t ibus_m2s,
  input  wb_s2m_t ibus_s2m,
  output wb_m2s_t dbus_m2s,
  input  wb_s2m_t dbus_s2m,
  output logic    retire_valid,
  output retire_t retire
);

  logic [31:0] pc;
  inst_t       inst;
  logic        inst_ready;
  logic        done;
  dec_t        dec;
  exe_t        exe;
  logic [31:0] rval1;
  logic [31:0] rval2;
  logic        we;
  logic [4:0]  wa;
  logic [31:0] wd;

  fetch_unit #(.reset_pc(reset_pc)) u_fetch (
    .clk_100mhz (clk_100mhz),
    .sys_rst    (sys_rst),
    .ibus_m2s   (ibus_m2s),
    .ibus_s2m   (ibus_s2m),
    .next_pc    (exe.next_pc),
    .done       (done),
    .pc         (pc),
    .inst       (inst),
    .inst_ready (inst_ready)
  );

  decode u_decode (
    .inst (inst),
    .dec  (dec)
  );

  register_file u_regs (
    .clk_100mhz (clk_100mhz),
    .sys_rst    (sys_rst),
    .rs1        (dec.rs1),
    .rs2        (dec.rs2),
    .we         (we),
    .wa         (wa),
    .wd         (wd),
    .rval1      (rval1),
    .rval2      (rval2)
  );

  execute u_execute (
    .dec   (dec),
    .pc    (pc),
    .rval1 (rval1),
    .rval2 (rval2),
    .exe   (exe)
  );

  mem_writeback u_mem_wb (
    .clk_100mhz   (clk_100mhz),
    .sys_rst      (sys_rst),
    .inst_ready   (inst_ready),
    .dec          (dec),
    .exe          (exe),
    .pc           (pc),
    .dbus_m2s     (dbus_m2s),
    .dbus_s2m     (dbus_s2m),
    .we           (we),
    .wa           (wa),
    .wd           (wd),
    .done         (done),
    .retire_valid (retire_valid),
    .retire       (retire)
  );

endmodule

//--- rtl/rv32_pkg.sv
package rv32_pkg;

  // base opcodes of the supported instruction groups
  typedef enum logic [6:0] {
    OPC_LUI    = 7'b0110111,
    OPC_AUIPC  = 7'b0010111,
    OPC_JAL    = 7'b1101111,
    OPC_JALR   = 7'b1100111,
    OPC_BRANCH = 7'b1100011,
    OPC_LOAD   = 7'b0000011,
    OPC_STORE  = 7'b0100011,
    OPC_OPIMM  = 7'b0010011,
    OPC_OP     = 7'b0110011
  } opcode_e;

  typedef enum logic [3:0] {
    OP, OPIMM, LUI, AUIPC, JAL, JALR, BRANCH, LOAD, STORE, NOP
  } itype_e;

  typedef enum logic [3:0] {
    ADD, SUB, SLL, SLT, SLTU, XOR, SRL, SRA, OR, AND
  } alu_func_e;

  typedef enum logic [2:0] {
    EQ, NE, LT, GE, LTU, GEU
  } br_func_e;

  // one instruction word, six ways to read it
  typedef union packed {
    struct packed {
      logic [6:0] funct7;
      logic [4:0] rs2;
      logic [4:0] rs1;
      logic [2:0] funct3;
      logic [4:0] rd;
      logic [6:0] opcode;
    } r_fmt;
    struct packed {
      logic [11:0] imm_11_0;
      logic [4:0]  rs1;
      logic [2:0]  funct3;
      logic [4:0]  rd;
      logic [6:0]  opcode;
    } i_fmt;
    struct packed {
      logic [6:0] imm_11_5;
      logic [4:0] rs2;
      logic [4:0] rs1;
      logic [2:0] funct3;
      logic [4:0] imm_4_0;
      logic [6:0] opcode;
    } s_fmt;
    struct packed {
      logic       imm_12;
      logic [5:0] imm_10_5;
      logic [4:0] rs2;
      logic [4:0] rs1;
      logic [2:0] funct3;
      logic [3:0] imm_4_1;
      logic       imm_11;
      logic [6:0] opcode;
    } b_fmt;
    struct packed {
      logic [19:0] imm_31_12;
      logic [4:0]  rd;
      logic [6:0]  opcode;
    } u_fmt;
    struct packed {
      logic       imm_20;
      logic [9:0] imm_10_1;
      logic       imm_11;
      logic [7:0] imm_19_12;
      logic [4:0] rd;
      logic [6:0] opcode;
    } j_fmt;
  } inst_t;

  typedef struct packed {
    itype_e      itype;
    alu_func_e   alu_func;
    br_func_e    br_func;
    logic [4:0]  rs1;
    logic [4:0]  rs2;
    logic [4:0]  rd;
    logic [31:0] imm;
  } dec_t;

  typedef struct packed {
    logic [31:0] result;
    logic [31:0] addr;
    logic [31:0] next_pc;
    logic [31:0] store_data;
  } exe_t;

  typedef struct packed {
    logic [31:0] pc;
    logic [4:0]  rd;
    logic        we;
    logic [31:0] wd;
    logic [31:0] next_pc;
  } retire_t;

  typedef struct packed {
    logic        cyc;
    logic        stb;
    logic        we;
    logic [31:0] adr;
    logic [31:0] dat;
    logic [3:0]  sel;
  } wb_m2s_t;

  typedef struct packed {
    logic        ack;
    logic [31:0] dat;
  } wb_s2m_t;

endpackage

//--- rv32_mini.f
rtl/rv32_pkg.sv
rtl/fetch_unit.sv
rtl/decode.sv
rtl/register_file.sv
rtl/execute.sv
rtl/mem_writeback.sv
rtl/rv32_mini_top.sv
verification/rv32_mini_properties.sv
verification/rv32_mini_tb.sv

//--- verification/rv32_mini_properties.sv
`timescale 1ns/100ps

module rv32_mini_properties import rv32_pkg::*; (
  input logic    clk_100mhz,
  input logic    sys_rst,
  input wb_m2s_t ibus_m2s,
  input wb_s2m_t ibus_s2m,
  input wb_m2s_t dbus_m2s,
  input wb_s2m_t dbus_s2m,
  input logic    retire_valid
);

  ibus_stb_cyc: assert property (@(posedge clk_100mhz) disable iff (sys_rst)
    ibus_m2s.stb |-> ibus_m2s.cyc) else $error("ibus stb high without cyc");

  dbus_stb_cyc: assert property (@(posedge clk_100mhz) disable iff (sys_rst)
    dbus_m2s.stb |-> dbus_m2s.cyc) else $error("dbus stb high without cyc");

  // request must not move while waiting for ack
  ibus_hold: assert property (@(posedge clk_100mhz) disable iff (sys_rst)
    (ibus_m2s.stb && !ibus_s2m.ack) |=> ($stable(ibus_m2s.adr) && $stable(ibus_m2s.we)))
    else $error("ibus adr or we changed before ack");

  dbus_hold: assert property (@(posedge clk_100mhz) disable iff (sys_rst)
    (dbus_m2s.stb && !dbus_s2m.ack) |=> ($stable(dbus_m2s.adr) && $stable(dbus_m2s.we)))
    else $error("dbus adr or we changed before ack");

  retire_pulse: assert property (@(posedge clk_100mhz) disable iff (sys_rst)
    retire_valid |=> !retire_valid) else $error("retire_valid high for more than one cycle");

  // one instruction in flight, so never both buses at once
  bus_exclusive: assert property (@(posedge clk_100mhz) disable iff (sys_rst)
    !(ibus_m2s.cyc && dbus_m2s.cyc)) else $error("ibus and dbus requested together");

endmodule

//--- verification/rv32_mini_tb.sv
`timescale 1ns/100ps

module rv32_mini_tb import rv32_pkg::*; ();

  localparam logic [31:0] RESET_PC = 32'h0;
  localparam int NUM_RETIRE      = 2000;
  localparam int RETIRE_TIMEOUT  = 50;
  localparam int FETCH_TIMEOUT   = 4;

  logic    clk_100mhz = 1'b0;
  logic    sys_rst    = 1'b1;
  wb_m2s_t ibus_m2s;
  wb_s2m_t ibus_s2m   = '0;
  wb_m2s_t dbus_m2s;
  wb_s2m_t dbus_s2m   = '0;
  logic    retire_valid;
  retire_t retire;

  logic [31:0] imem [256];
  logic [31:0] dmem [256];   // slave copy
  logic [31:0] m_dmem [256]; // model copy
  logic [31:0] m_regs [32];
  logic [31:0] m_pc;

  int          iwait = -1;
  int          dwait = -1;
  int          d_count = 0;  // data accesses acked so far
  int          d_count_seen = 0;
  logic        d_we = 1'b0;
  logic [31:0] d_adr = '0;
  logic [31:0] d_dat = '0;

  always #5 clk_100mhz = ~clk_100mhz;

  rv32_mini_top #(.reset_pc(RESET_PC)) dut (
    .clk_100mhz   (clk_100mhz),
    .sys_rst      (sys_rst),
    .ibus_m2s     (ibus_m2s),
    .ibus_s2m     (ibus_s2m),
    .dbus_m2s     (dbus_m2s),
    .dbus_s2m     (dbus_s2m),
    .retire_valid (retire_valid),
    .retire       (retire)
  );

  bind rv32_mini_top rv32_mini_properties props (
    .clk_100mhz   (clk_100mhz),
    .sys_rst      (sys_rst),
    .ibus_m2s     (ibus_m2s),
    .ibus_s2m     (ibus_s2m),
    .dbus_m2s     (dbus_m2s),
    .dbus_s2m     (dbus_s2m),
    .retire_valid (retire_valid)
  );

  // instruction memory slave with 0 to 3 wait states
  always @(posedge clk_100mhz) begin
    if (sys_rst) begin
      ibus_s2m <= '0;
      iwait = -1;
    end else if (ibus_s2m.ack) begin
      ibus_s2m.ack <= 1'b0;
    end else if (ibus_m2s.cyc && ibus_m2s.stb) begin
      if (iwait < 0) iwait = $urandom_range(3, 0);
      if (iwait == 0) begin
        check_value("ibus_m2s.adr", m_pc, ibus_m2s.adr); // fetch in program order
        check_value("ibus_m2s.we", 32'h0, {31'b0, ibus_m2s.we});
        check_value("ibus_m2s.sel", 32'hf, {28'b0, ibus_m2s.sel});
        ibus_s2m.ack <= 1'b1;
        ibus_s2m.dat <= imem[ibus_m2s.adr[9:2]];
        iwait = -1;
      end else begin
        iwait--;
      end
    end
  end

  // data memory slave refilled during reset
  always @(posedge clk_100mhz) begin
    if (sys_rst) begin
      dbus_s2m <= '0;
      dwait = -1;
      for (int i = 0; i < 256; i++) dmem[i] = $urandom;
    end else if (dbus_s2m.ack) begin
      dbus_s2m.ack <= 1'b0;
    end else if (dbus_m2s.cyc && dbus_m2s.stb) begin
      if (dwait < 0) dwait = $urandom_range(3, 0);
      if (dwait == 0) begin
        check_value("dbus_m2s.sel", 32'hf, {28'b0, dbus_m2s.sel});
        dbus_s2m.ack <= 1'b1;
        dbus_s2m.dat <= dmem[dbus_m2s.adr[9:2]];
        if (dbus_m2s.we) dmem[dbus_m2s.adr[9:2]] = dbus_m2s.dat;
        d_we  = dbus_m2s.we;
        d_adr = dbus_m2s.adr;
        d_dat = dbus_m2s.dat;
        d_count++;
        dwait = -1;
      end else begin
        dwait--;
      end
    end
  end

  task automatic fail_run(input string why);
    $display("%s", why);
    $display("Simulation FAILED");
    $fatal(1, "stopped at first error");
  endtask

  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    if (actual !== expected)
      fail_run($sformatf("Fail %s expected %08h actual %08h", name, expected, actual));
  endtask

  // random legal encoding with x0 as load and store base
  function automatic logic [31:0] gen_inst();
    logic [4:0]  rd;
    logic [4:0]  rs1;
    logic [4:0]  rs2;
    logic [2:0]  f3;
    logic [11:0] imm12;
    logic [12:0] boff;
    logic [20:0] joff;
    int          off;
    rd    = 5'($urandom);
    rs1   = 5'($urandom);
    rs2   = 5'($urandom);
    f3    = 3'($urandom);
    imm12 = 12'(($urandom % 256) * 4); // word offset under 1 KB
    case (int'($urandom % 10))
      0, 1: begin
        if ((f3 == 3'b000 || f3 == 3'b101) && $urandom % 2 == 1)
          gen_inst = {7'h20, rs2, rs1, f3, rd, 7'h33};
        else
          gen_inst = {7'h00, rs2, rs1, f3, rd, 7'h33};
      end
      2, 3: begin
        imm12 = 12'($urandom);
        if (f3 == 3'b001) imm12[11:5] = 7'h00;
        else if (f3 == 3'b101) imm12[11:5] = imm12[11] ? 7'h20 : 7'h00;
        gen_inst = {imm12, rs1, f3, rd, 7'h13};
      end
      4: gen_inst = {20'($urandom), rd, ($urandom % 2 == 1) ? 7'h37 : 7'h17};
      5: begin
        off = (int'($urandom % 128) - 64) * 4;
        if (off == 0) off = 4; // no jump onto itself
        joff = 21'(off);
        gen_inst = {joff[20], joff[10:1], joff[11], joff[19:12], rd, 7'h6f};
      end
      6: gen_inst = {imm12, 5'd0, 3'b000, rd, 7'h67};
      7: begin
        case (int'($urandom % 6))
          0: f3 = 3'b000;
          1: f3 = 3'b001;
          2: f3 = 3'b100;
          3: f3 = 3'b101;
          4: f3 = 3'b110;
          default: f3 = 3'b111;
        endcase
        off = (int'($urandom % 64) - 32) * 4;
        if (off == 0) off = 8;
        boff = 13'(off);
        gen_inst = {boff[12], boff[10:5], rs2, rs1, f3, boff[4:1], boff[11], 7'h63};
      end
      8: gen_inst = {imm12, 5'd0, 3'b010, rd, 7'h03};
      default: gen_inst = {imm12[11:5], rs2, 5'd0, 3'b010, imm12[4:0], 7'h23};
    endcase
  endfunction

  function automatic logic [31:0] model_alu(input logic [2:0] f3, input logic alt,
                                            input logic [31:0] x, input logic [31:0] y);
    logic [4:0] sh;
    sh = y[4:0];
    case (f3)
      3'b000: model_alu = alt ? x - y : x + y;
      3'b001: model_alu = x << sh;
      3'b010: model_alu = {31'b0, $signed(x) < $signed(y)};
      3'b011: model_alu = {31'b0, x < y};
      3'b100: model_alu = x ^ y;
      3'b101: begin
        if (alt) model_alu = $signed(x) >>> sh; // arithmetic
        else model_alu = x >> sh;
      end
      3'b110: model_alu = x | y;
      default: model_alu = x & y;
    endcase
  endfunction

  function automatic logic branch_taken(input logic [2:0] f3, input logic [31:0] x,
                                        input logic [31:0] y);
    case (f3)
      3'b000: branch_taken = (x == y);
      3'b001: branch_taken = (x != y);
      3'b100: branch_taken = ($signed(x) < $signed(y));
      3'b101: branch_taken = ($signed(x) >= $signed(y));
      3'b110: branch_taken = (x < y);
      default: branch_taken = (x >= y);
    endcase
  endfunction

  // one instruction of the reference model, compared with the retire record
  task automatic step_model();
    logic [31:0] ins;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] imm_i;
    logic [31:0] exp_wd;
    logic [31:0] exp_next;
    logic [31:0] exp_addr;
    logic [4:0]  rd;
    logic        has_rd;
    logic        is_ld;
    logic        is_st;
    ins      = imem[m_pc[9:2]];
    rd       = ins[11:7];
    a        = m_regs[ins[19:15]];
    b        = m_regs[ins[24:20]];
    imm_i    = {{20{ins[31]}}, ins[31:20]};
    exp_next = m_pc + 32'd4;
    exp_wd   = '0;
    exp_addr = '0;
    has_rd   = 1'b1;
    is_ld    = 1'b0;
    is_st    = 1'b0;
    case (ins[6:0])
      7'h33: exp_wd = model_alu(ins[14:12], ins[30], a, b);
      7'h13: exp_wd = model_alu(ins[14:12], ins[14:12] == 3'b101 && ins[30], a, imm_i);
      7'h37: exp_wd = {ins[31:12], 12'b0};
      7'h17: exp_wd = m_pc + {ins[31:12], 12'b0};
      7'h6f: begin
        exp_wd   = m_pc + 32'd4;
        exp_next = m_pc + {{11{ins[31]}}, ins[31], ins[19:12], ins[20], ins[30:21], 1'b0};
      end
      7'h67: begin
        exp_wd   = m_pc + 32'd4;
        exp_next = (a + imm_i) & ~32'd1;
      end
      7'h63: begin
        has_rd = 1'b0;
        if (branch_taken(ins[14:12], a, b))
          exp_next = m_pc + {{19{ins[31]}}, ins[31], ins[7], ins[30:25], ins[11:8], 1'b0};
      end
      7'h03: begin
        is_ld    = 1'b1;
        exp_addr = a + imm_i;
        exp_wd   = m_dmem[exp_addr[9:2]];
      end
      7'h23: begin
        has_rd   = 1'b0;
        is_st    = 1'b1;
        exp_addr = a + {{20{ins[31]}}, ins[31:25], ins[11:7]};
      end
      default: has_rd = 1'b0;
    endcase
    if (!has_rd) rd = 5'd0; // branch and store report no rd

    check_value("retire.pc", m_pc, retire.pc);
    check_value("retire.rd", {27'b0, rd}, {27'b0, retire.rd});
    check_value("retire.we", {31'b0, has_rd && rd != 5'd0}, {31'b0, retire.we});
    if (has_rd) check_value("retire.wd", exp_wd, retire.wd);
    check_value("retire.next_pc", exp_next, retire.next_pc);
    check_value("dbus accesses", {31'b0, is_ld || is_st}, 32'(d_count - d_count_seen));
    if (is_ld || is_st) begin
      check_value("dbus_m2s.we", {31'b0, is_st}, {31'b0, d_we});
      check_value("dbus_m2s.adr", exp_addr, d_adr);
    end
    if (is_st) begin
      check_value("dbus_m2s.dat", b, d_dat);
      m_dmem[exp_addr[9:2]] = b;
    end
    d_count_seen = d_count;

    if (has_rd && rd != 5'd0) m_regs[rd] = exp_wd;
    m_pc = exp_next;
  endtask

  task automatic wait_fetch_start();
    int cycles;
    cycles = 0;
    @(negedge clk_100mhz);
    while (!(ibus_m2s.cyc && ibus_m2s.stb)) begin
      if (cycles == FETCH_TIMEOUT) fail_run("first instruction fetch did not start after reset");
      cycles++;
      @(negedge clk_100mhz);
    end
  endtask

  task automatic wait_retire(input int n);
    int cycles;
    cycles = 0;
    @(negedge clk_100mhz);
    while (!retire_valid) begin
      if (cycles == RETIRE_TIMEOUT)
        fail_run($sformatf("instruction %0d did not retire within %0d cycles", n, cycles));
      cycles++;
      @(negedge clk_100mhz);
    end
  endtask

  initial begin
    void'($urandom(88));
    for (int i = 0; i < 256; i++) imem[i] = gen_inst();
    for (int i = 0; i < 32; i++) m_regs[i] = '0;
    m_pc = RESET_PC;

    // nothing may move on either bus while in reset
    for (int c = 0; c < 5; c++) begin
      @(posedge clk_100mhz);
      if (c == 4) sys_rst <= 1'b0;
      @(negedge clk_100mhz);
      if (ibus_m2s.cyc !== 1'b0 || dbus_m2s.cyc !== 1'b0 || retire_valid !== 1'b0)
        fail_run("bus request or retire seen while reset was high");
    end
    for (int i = 0; i < 256; i++) m_dmem[i] = dmem[i];

    wait_fetch_start();
    for (int n = 0; n < NUM_RETIRE; n++) begin
      wait_retire(n);
      step_model();
    end

    $display("Simulation PASSED");
    $finish;
  end

endmodule
